//--- hw/lsu_pkg.sv
package lsu_pkg;

   // channels sharing the ram.
   localparam int N_PORTS = 2;

   // data width, also the bit-cycles per serial phase.
   localparam int XLEN = 32;

   // word address bits, 256 words.
   localparam int RAM_AW = 8;

   localparam int CNT_W = $clog2(XLEN);
   localparam int ARB_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

   typedef logic [XLEN-1:0] word_t;

   typedef logic [3:0] sel_t;

   // bit 2 set is zero-extend, bits 1:0 are the size.
   typedef logic [2:0] funct3_t;

   // low two bits are the byte position.
   typedef logic [RAM_AW+1:0] addr_t;

endpackage

//--- hw/serial_mem_if.sv
module serial_mem_if (
   input  logic             i_clk,
   input  logic             i_arst_n,
   input  logic             i_en,
   input  logic             i_init,
   input  logic             i_cmd,
   input  logic [1:0]       i_bytecnt,
   input  lsu_pkg::funct3_t i_funct3,
   input  logic [1:0]       i_lsb,
   input  logic             i_rs2,
   input  lsu_pkg::word_t   i_wb_rdt,
   input  logic             i_wb_ack,
   output logic             o_rd,
   output logic             o_misalign,
   output lsu_pkg::word_t   o_wb_dat,
   output lsu_pkg::sel_t    o_wb_sel,
   output logic             o_wb_we
);

   logic [7:0] lane [4];
   logic [3:0] lane_en;
   logic [1:0] bytepos;
   logic [1:0] dat_sel;
   logic       dat_cur;
   logic       dat_valid;
   logic       signbit;
   logic       is_signed;
   logic       is_word;
   logic       is_half;
   logic       is_byte;
   logic       wbyte0;
   logic       wbyte1;
   logic       wbyte2;
   logic       wbyte3;

   assign is_signed = ~i_funct3[2];
   assign is_word   = i_funct3[1];
   assign is_half   = i_funct3[0];
   assign is_byte   = ~|i_funct3[1:0];

   // upper byte counts read their own lane, lower ones are offset.
   assign dat_sel = i_bytecnt[1] ? i_bytecnt : (i_bytecnt | bytepos);
   assign dat_cur = lane[dat_sel][0];

   // still inside the loaded width.
   assign dat_valid = is_word | (i_bytecnt == 2'b00) | (is_half & ~i_bytecnt[1]);
   assign o_rd      = dat_valid ? dat_cur : (signbit & is_signed);

   // replication during init.
   // byte 0 goes to every lane, later bytes only where the position allows.
   assign wbyte0 = (i_bytecnt == 2'b00);
   assign wbyte1 = (i_bytecnt == 2'b01) & ~bytepos[0];
   assign wbyte2 = (i_bytecnt == 2'b10) & ~bytepos[1];
   assign wbyte3 = (i_bytecnt == 2'b11) & ~bytepos[1];

   assign lane_en[0] = i_en & (i_init ? wbyte0 : (dat_sel == 2'd0));
   assign lane_en[1] = i_en & (i_init ? (wbyte0 | wbyte1) : (dat_sel == 2'd1));
   assign lane_en[2] = i_en & (i_init ? (wbyte0 | wbyte2) : (dat_sel == 2'd2));
   assign lane_en[3] = i_en & (i_init ? (wbyte0 | wbyte1 | wbyte3) : (dat_sel == 2'd3));

   assign o_wb_sel[3] = is_word | (is_half & bytepos[1]) | (bytepos == 2'b11);
   assign o_wb_sel[2] = is_word | (bytepos == 2'b10);
   assign o_wb_sel[1] = ((is_word | is_half) & ~bytepos[1]) | (bytepos == 2'b01);
   assign o_wb_sel[0] = (bytepos == 2'b00);

   assign o_wb_dat = {lane[3], lane[2], lane[1], lane[0]};
   assign o_wb_we  = i_cmd;

   always_ff @(posedge i_clk) begin
      if (i_init)
         bytepos <= i_lsb;
      for (int b = 0; b < 4; b++) begin
         if (i_wb_ack && !i_cmd)
            lane[b] <= i_wb_rdt[8*b +: 8];
         else if (lane_en[b])
            lane[b] <= {i_rs2, lane[b][7:1]};
      end
      // last bit read inside the width, used for sign fill.
      if (i_en && !i_init && dat_valid)
         signbit <= dat_cur;
   end

   // held after init until the next command.
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         o_misalign <= 1'b0;
      else if (i_init)
         o_misalign <= (bytepos[0] & ~is_byte) | (bytepos[1] & is_word);
   end

   // a misaligned access never reaches memory.
   a_aligned_on_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_wb_ack |-> !o_misalign);

endmodule

//--- hw/lsu_sequencer.sv
module lsu_sequencer (
   input  logic                       i_clk,
   input  logic                       i_arst_n,
   input  logic                       i_start,
   input  logic                       i_we,
   input  lsu_pkg::funct3_t           i_funct3,
   input  lsu_pkg::addr_t             i_addr,
   input  logic                       i_wbit,
   input  logic                       i_misalign,
   input  logic                       i_ack,
   output logic                       o_en,
   output logic                       o_init,
   output logic                       o_cmd,
   output logic [1:0]                 o_bytecnt,
   output lsu_pkg::funct3_t           o_funct3,
   output logic [1:0]                 o_lsb,
   output logic                       o_rs2,
   output logic                       o_req,
   output logic [lsu_pkg::RAM_AW-1:0] o_word_addr,
   output logic                       o_wbit_req,
   output logic                       o_rbit_valid,
   output logic                       o_done,
   output logic                       o_misalign
);

   import lsu_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_INIT,
      S_REQ,
      S_READ,
      S_FIN
   } state_t;

   state_t           state;
   logic [CNT_W-1:0] cnt;
   addr_t            addr_q;
   logic             last_bit;
   logic             abort;

   assign last_bit = (cnt == CNT_W'(XLEN - 1));

   // misaligned access ends right after init, no memory request.
   assign abort = (state == S_REQ) & i_misalign;

   assign o_init       = (state == S_INIT);
   assign o_rbit_valid = (state == S_READ);
   assign o_en         = o_init | o_rbit_valid;
   assign o_wbit_req   = o_init;
   assign o_rs2        = o_init & i_wbit;
   assign o_bytecnt    = cnt[CNT_W-1:CNT_W-2];
   assign o_lsb        = addr_q[1:0];
   assign o_word_addr  = addr_q[RAM_AW+1:2];
   assign o_req        = (state == S_REQ) & ~i_misalign;
   assign o_done       = (state == S_FIN) | abort;
   assign o_misalign   = o_done & i_misalign;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= S_IDLE;
         cnt   <= '0;
      end else begin
         // wraps back to zero at the end of each phase.
         if (o_en)
            cnt <= cnt + 1'b1;
         case (state)
            S_IDLE: begin
               if (i_start)
                  state <= S_INIT;
            end
            S_INIT: begin
               if (last_bit)
                  state <= S_REQ;
            end
            S_REQ: begin
               if (i_misalign)
                  state <= S_IDLE;
               else if (i_ack)
                  state <= o_cmd ? S_FIN : S_READ;
            end
            S_READ: begin
               if (last_bit)
                  state <= S_FIN;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // command latched only when idle.
   always_ff @(posedge i_clk) begin
      if (state == S_IDLE && i_start) begin
         o_cmd    <= i_we;
         o_funct3 <= i_funct3;
         addr_q   <= i_addr;
      end
   end

   a_req_after_init: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      $rose(o_req) |-> (state == S_REQ) && ($past(state) == S_INIT));

endmodule

//--- hw/mem_arbiter.sv
module mem_arbiter (
   input  logic                       i_clk,
   input  logic                       i_arst_n,
   input  logic [lsu_pkg::N_PORTS-1:0] i_req,
   input  logic [lsu_pkg::N_PORTS-1:0] i_we,
   input  lsu_pkg::sel_t              i_sel [lsu_pkg::N_PORTS],
   input  logic [lsu_pkg::RAM_AW-1:0] i_addr [lsu_pkg::N_PORTS],
   input  lsu_pkg::word_t             i_wdat [lsu_pkg::N_PORTS],
   input  logic                       i_mem_ack,
   input  lsu_pkg::word_t             i_mem_rdt,
   output logic [lsu_pkg::N_PORTS-1:0] o_ack,
   output lsu_pkg::word_t             o_rdt,
   output logic                       o_mem_req,
   output logic                       o_mem_we,
   output lsu_pkg::sel_t              o_mem_sel,
   output logic [lsu_pkg::RAM_AW-1:0] o_mem_addr,
   output lsu_pkg::word_t             o_mem_wdat
);

   import lsu_pkg::*;

   logic [N_PORTS-1:0] grant;
   logic [N_PORTS-1:0] pick;
   logic [N_PORTS-1:0] gnt_now;
   logic [ARB_W-1:0]   last;
   logic [ARB_W-1:0]   pick_idx;

   // search from the port after the last winner.
   always_comb begin
      int unsigned idx;
      pick     = '0;
      pick_idx = last;
      for (int k = N_PORTS; k >= 1; k--) begin
         idx = (int'(last) + k) % N_PORTS;
         if (i_req[idx]) begin
            pick      = '0;
            pick[idx] = 1'b1;
            pick_idx  = ARB_W'(idx);
         end
      end
   end

   // new grant is forwarded in the cycle it is chosen.
   assign gnt_now   = (|grant) ? grant : pick;
   assign o_mem_req = |(i_req & gnt_now);

   always_comb begin
      o_mem_we   = 1'b0;
      o_mem_sel  = '0;
      o_mem_addr = '0;
      o_mem_wdat = '0;
      for (int p = 0; p < N_PORTS; p++) begin
         if (gnt_now[p]) begin
            o_mem_we   = i_we[p];
            o_mem_sel  = i_sel[p];
            o_mem_addr = i_addr[p];
            o_mem_wdat = i_wdat[p];
         end
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         grant <= '0;
         last  <= '0;
      end else if (i_mem_ack) begin
         grant <= '0;
      end else if (~|grant && |pick) begin
         grant <= pick;
         last  <= pick_idx;
      end
   end

   assign o_ack = grant & {N_PORTS{i_mem_ack}};
   assign o_rdt = i_mem_rdt;

   a_grant_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      $onehot0(grant));

   // ack belongs to the port forwarded one cycle earlier.
   a_ack_granted: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      |o_ack |-> $past(o_mem_req) && (grant == $past(gnt_now)));

endmodule

//--- hw/word_ram.sv
module word_ram (
   input  logic                       i_clk,
   input  logic                       i_arst_n,
   input  logic                       i_req,
   input  logic                       i_we,
   input  lsu_pkg::sel_t              i_sel,
   input  logic [lsu_pkg::RAM_AW-1:0] i_addr,
   input  lsu_pkg::word_t             i_wdat,
   output logic                       o_ack,
   output lsu_pkg::word_t             o_rdt
);

   import lsu_pkg::*;

   word_t mem [2**RAM_AW];
   logic  take;

   // request still high in the ack cycle is not taken again.
   assign take = i_req & ~o_ack;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         o_ack <= 1'b0;
      else
         o_ack <= take;
   end

   always_ff @(posedge i_clk) begin
      if (take)
         o_rdt <= mem[i_addr];
      // write lands on the ack edge.
      if (o_ack && i_req && i_we) begin
         for (int b = 0; b < $bits(sel_t); b++) begin
            if (i_sel[b])
               mem[i_addr][8*b +: 8] <= i_wdat[8*b +: 8];
         end
      end
   end

endmodule

//--- hw/lsu_top.sv
module lsu_top (
   input  logic             i_clk,
   input  logic             i_arst_n,
   input  logic             i_start_0,
   input  logic             i_we_0,
   input  lsu_pkg::funct3_t i_funct3_0,
   input  lsu_pkg::addr_t   i_addr_0,
   input  logic             i_wbit_0,
   output logic             o_wbit_req_0,
   output logic             o_rbit_0,
   output logic             o_rbit_valid_0,
   output logic             o_done_0,
   output logic             o_misalign_0,
   input  logic             i_start_1,
   input  logic             i_we_1,
   input  lsu_pkg::funct3_t i_funct3_1,
   input  lsu_pkg::addr_t   i_addr_1,
   input  logic             i_wbit_1,
   output logic             o_wbit_req_1,
   output logic             o_rbit_1,
   output logic             o_rbit_valid_1,
   output logic             o_done_1,
   output logic             o_misalign_1
);

   import lsu_pkg::*;

   logic               start [N_PORTS];
   logic               we [N_PORTS];
   funct3_t            funct3 [N_PORTS];
   addr_t              addr [N_PORTS];
   logic               wbit [N_PORTS];
   logic               wbit_req [N_PORTS];
   logic               rbit [N_PORTS];
   logic               rbit_valid [N_PORTS];
   logic               done [N_PORTS];
   logic               misalign [N_PORTS];

   logic               en [N_PORTS];
   logic               init [N_PORTS];
   logic               cmd [N_PORTS];
   logic [1:0]         bytecnt [N_PORTS];
   funct3_t            funct3_q [N_PORTS];
   logic [1:0]         lsb [N_PORTS];
   logic               rs2 [N_PORTS];
   logic               mif_misalign [N_PORTS];
   word_t              wb_dat [N_PORTS];
   sel_t               wb_sel [N_PORTS];
   logic [RAM_AW-1:0]  word_addr [N_PORTS];
   logic [N_PORTS-1:0] wb_we;
   logic [N_PORTS-1:0] req;
   logic [N_PORTS-1:0] ack;
   word_t              rdt;

   logic               mem_req;
   logic               mem_we;
   sel_t               mem_sel;
   logic [RAM_AW-1:0]  mem_addr;
   word_t              mem_wdat;
   logic               mem_ack;
   word_t              mem_rdt;

   assign start[0]  = i_start_0;
   assign we[0]     = i_we_0;
   assign funct3[0] = i_funct3_0;
   assign addr[0]   = i_addr_0;
   assign wbit[0]   = i_wbit_0;
   assign start[1]  = i_start_1;
   assign we[1]     = i_we_1;
   assign funct3[1] = i_funct3_1;
   assign addr[1]   = i_addr_1;
   assign wbit[1]   = i_wbit_1;

   assign o_wbit_req_0   = wbit_req[0];
   assign o_rbit_0       = rbit[0];
   assign o_rbit_valid_0 = rbit_valid[0];
   assign o_done_0       = done[0];
   assign o_misalign_0   = misalign[0];
   assign o_wbit_req_1   = wbit_req[1];
   assign o_rbit_1       = rbit[1];
   assign o_rbit_valid_1 = rbit_valid[1];
   assign o_done_1       = done[1];
   assign o_misalign_1   = misalign[1];

   for (genvar c = 0; c < N_PORTS; c++) begin : g_ch
      lsu_sequencer seq_i (
         .i_clk        (i_clk),
         .i_arst_n     (i_arst_n),
         .i_start      (start[c]),
         .i_we         (we[c]),
         .i_funct3     (funct3[c]),
         .i_addr       (addr[c]),
         .i_wbit       (wbit[c]),
         .i_misalign   (mif_misalign[c]),
         .i_ack        (ack[c]),
         .o_en         (en[c]),
         .o_init       (init[c]),
         .o_cmd        (cmd[c]),
         .o_bytecnt    (bytecnt[c]),
         .o_funct3     (funct3_q[c]),
         .o_lsb        (lsb[c]),
         .o_rs2        (rs2[c]),
         .o_req        (req[c]),
         .o_word_addr  (word_addr[c]),
         .o_wbit_req   (wbit_req[c]),
         .o_rbit_valid (rbit_valid[c]),
         .o_done       (done[c]),
         .o_misalign   (misalign[c])
      );

      serial_mem_if mif_i (
         .i_clk      (i_clk),
         .i_arst_n   (i_arst_n),
         .i_en       (en[c]),
         .i_init     (init[c]),
         .i_cmd      (cmd[c]),
         .i_bytecnt  (bytecnt[c]),
         .i_funct3   (funct3_q[c]),
         .i_lsb      (lsb[c]),
         .i_rs2      (rs2[c]),
         .i_wb_rdt   (rdt),
         .i_wb_ack   (ack[c]),
         .o_rd       (rbit[c]),
         .o_misalign (mif_misalign[c]),
         .o_wb_dat   (wb_dat[c]),
         .o_wb_sel   (wb_sel[c]),
         .o_wb_we    (wb_we[c])
      );
   end

   mem_arbiter arb_i (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_req      (req),
      .i_we       (wb_we),
      .i_sel      (wb_sel),
      .i_addr     (word_addr),
      .i_wdat     (wb_dat),
      .i_mem_ack  (mem_ack),
      .i_mem_rdt  (mem_rdt),
      .o_ack      (ack),
      .o_rdt      (rdt),
      .o_mem_req  (mem_req),
      .o_mem_we   (mem_we),
      .o_mem_sel  (mem_sel),
      .o_mem_addr (mem_addr),
      .o_mem_wdat (mem_wdat)
   );

   word_ram ram_i (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_req    (mem_req),
      .i_we     (mem_we),
      .i_sel    (mem_sel),
      .i_addr   (mem_addr),
      .i_wdat   (mem_wdat),
      .o_ack    (mem_ack),
      .o_rdt    (mem_rdt)
   );

endmodule

//--- tests/tb_lsu_top.sv
module tb_lsu_top;

   timeunit 1ns;
   timeprecision 100ps;

   import lsu_pkg::*;

   localparam int N_CH = 2;
   // 100 commands per channel, 66 cycles each plus one access of wait.
   localparam int TIMEOUT_CYCLES = 20000;
   localparam int DONE_WAIT = 200;
   localparam int RAND_WORDS = 8;
   localparam int RAND_CMDS = 92;

   localparam funct3_t F_B  = 3'd0;
   localparam funct3_t F_H  = 3'd1;
   localparam funct3_t F_W  = 3'd2;
   localparam funct3_t F_BU = 3'd4;
   localparam funct3_t F_HU = 3'd5;

   logic    clk;
   logic    arst_n;
   logic    start [N_CH];
   logic    we [N_CH];
   funct3_t f3 [N_CH];
   addr_t   addr [N_CH];
   logic    wbit [N_CH];
   logic    wbit_req [N_CH];
   logic    rbit [N_CH];
   logic    rbit_valid [N_CH];
   logic    done [N_CH];
   logic    misalign [N_CH];

   word_t   shadow [2**RAM_AW];
   int      seed;
   int      cycles;
   int      n_checks;
   int      n_mismatch;
   int      n_other;
   word_t   q_got [$];
   word_t   q_exp [$];
   logic    q_is_flag [$];
   string   q_msg [$];

   lsu_top dut_i (
      .i_clk          (clk),
      .i_arst_n       (arst_n),
      .i_start_0      (start[0]),
      .i_we_0         (we[0]),
      .i_funct3_0     (f3[0]),
      .i_addr_0       (addr[0]),
      .i_wbit_0       (wbit[0]),
      .o_wbit_req_0   (wbit_req[0]),
      .o_rbit_0       (rbit[0]),
      .o_rbit_valid_0 (rbit_valid[0]),
      .o_done_0       (done[0]),
      .o_misalign_0   (misalign[0]),
      .i_start_1      (start[1]),
      .i_we_1         (we[1]),
      .i_funct3_1     (f3[1]),
      .i_addr_1       (addr[1]),
      .i_wbit_1       (wbit[1]),
      .o_wbit_req_1   (wbit_req[1]),
      .o_rbit_1       (rbit[1]),
      .o_rbit_valid_1 (rbit_valid[1]),
      .o_done_1       (done[1]),
      .o_misalign_1   (misalign[1])
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
         $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                  n_checks, n_mismatch, n_other);
         $display("TEST FAIL");
         $finish;
      end
   end

   // half must sit on an even byte, word on a multiple of four.
   function automatic logic ref_misalign(input funct3_t fn, input logic [1:0] pos);
      logic mis;
      case (fn[1:0])
         2'd1:    mis = pos[0];
         2'd2:    mis = |pos;
         default: mis = 1'b0;
      endcase
      return mis;
   endfunction

   function automatic word_t ref_load(input word_t w, input funct3_t fn, input logic [1:0] pos);
      logic [7:0]  b;
      logic [15:0] h;
      word_t       r;
      b = w[8*pos +: 8];
      h = w[16*pos[1] +: 16];
      case (fn[1:0])
         2'd0:    r = fn[2] ? {24'd0, b} : {{24{b[7]}}, b};
         2'd1:    r = fn[2] ? {16'd0, h} : {{16{h[15]}}, h};
         default: r = w;
      endcase
      return r;
   endfunction

   function automatic word_t ref_store(input word_t old, input word_t d, input funct3_t fn,
                                       input logic [1:0] pos);
      word_t r;
      r = old;
      case (fn[1:0])
         2'd0:    r[8*pos +: 8] = d[7:0];
         2'd1:    r[16*pos[1] +: 16] = d[15:0];
         default: r = d;
      endcase
      return r;
   endfunction

   function automatic word_t fill_word(input int idx);
      logic [7:0] a;
      a = idx[7:0];
      return {a ^ 8'h3C, ~a, a, a + 8'h5B};
   endfunction

   function automatic addr_t mk_addr(input int w, input int pos);
      addr_t a;
      a = {w[RAM_AW-1:0], pos[1:0]};
      return a;
   endfunction

   function automatic funct3_t pick_funct3(input logic is_store, input int unsigned r);
      funct3_t fn;
      if (is_store) begin
         case (r % 3)
            0:       fn = F_B;
            1:       fn = F_H;
            default: fn = F_W;
         endcase
      end else begin
         case (r % 5)
            0:       fn = F_B;
            1:       fn = F_H;
            2:       fn = F_W;
            3:       fn = F_BU;
            default: fn = F_HU;
         endcase
      end
      return fn;
   endfunction

   task automatic check_word(input word_t got, input word_t exp, input string msg);
      n_checks++;
      if (got !== exp) begin
         n_mismatch++;
         $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string msg);
      n_checks++;
      if (got !== exp) begin
         n_mismatch++;
         $display("Mismatch at %0t: %s, got %b, expected %b", $time, msg, got, exp);
      end
   endtask

   task automatic report_error(input string msg);
      n_other++;
      $display("Error at %0t: %s", $time, msg);
   endtask

   task automatic push_result(input logic is_flag, input word_t got, input word_t exp,
                              input string msg);
      q_is_flag.push_back(is_flag);
      q_got.push_back(got);
      q_exp.push_back(exp);
      q_msg.push_back(msg);
   endtask

   always @(negedge clk) begin : compare
      logic  is_flag;
      word_t got;
      word_t exp;
      string msg;
      while (q_got.size() > 0) begin
         is_flag = q_is_flag.pop_front();
         got     = q_got.pop_front();
         exp     = q_exp.pop_front();
         msg     = q_msg.pop_front();
         if (is_flag)
            check_flag(got[0], exp[0], msg);
         else
            check_word(got, exp, msg);
      end
   end

   task automatic check_idle();
      for (int c = 0; c < N_CH; c++) begin
         check_flag(done[c], 1'b0, $sformatf("ch%0d o_done before first start", c));
         check_flag(rbit_valid[c], 1'b0, $sformatf("ch%0d o_rbit_valid before first start", c));
         check_flag(wbit_req[c], 1'b0, $sformatf("ch%0d o_wbit_req before first start", c));
      end
   endtask

   // one full command, store data shifted in lsb first during init.
   task automatic run_cmd(input int ch, input logic is_store, input funct3_t fn,
                          input addr_t ad, input word_t wd);
      word_t got;
      logic  mis;
      logic  exp_mis;
      logic  seen_done;
      int    nbits;
      int    wait_cyc;
      int    idx;
      string msg;
      got       = '0;
      mis       = 1'b0;
      seen_done = 1'b0;
      nbits     = 0;
      wait_cyc  = 0;
      idx       = int'(ad[RAM_AW+1:2]);
      msg       = $sformatf("ch%0d %s f3=%0d addr=%h", ch, is_store ? "store" : "load", fn, ad);
      @(posedge clk);
      start[ch] <= 1'b1;
      we[ch]    <= is_store;
      f3[ch]    <= fn;
      addr[ch]  <= ad;
      for (int k = 0; k < XLEN; k++) begin
         @(posedge clk);
         start[ch] <= 1'b0;
         wbit[ch]  <= wd[k];
         @(negedge clk);
         if (!wbit_req[ch])
            report_error($sformatf("%s: o_wbit_req low in init cycle %0d", msg, k));
      end
      @(posedge clk);
      wbit[ch] <= 1'b0;
      while (!seen_done && wait_cyc < DONE_WAIT) begin
         @(negedge clk);
         wait_cyc++;
         if (rbit_valid[ch]) begin
            if (nbits < XLEN)
               got[nbits] = rbit[ch];
            nbits++;
         end
         if (done[ch]) begin
            seen_done = 1'b1;
            mis       = misalign[ch];
         end
      end
      if (!seen_done) begin
         report_error($sformatf("%s: o_done never came", msg));
      end else begin
         exp_mis = ref_misalign(fn, ad[1:0]);
         push_result(1'b1, word_t'(mis), word_t'(exp_mis), {msg, " misalign"});
         if (nbits != ((is_store || exp_mis) ? 0 : XLEN))
            report_error($sformatf("%s: %0d read bits came out", msg, nbits));
         if (!exp_mis) begin
            if (is_store)
               shadow[idx] = ref_store(shadow[idx], wd, fn, ad[1:0]);
            else
               push_result(1'b0, got, ref_load(shadow[idx], fn, ad[1:0]), {msg, " data"});
         end
      end
   endtask

   task automatic random_cmds(input int ch, input int base);
      logic    is_store;
      funct3_t fn;
      int      w;
      int      pos;
      word_t   d;
      for (int i = 0; i < RAND_WORDS; i++)
         run_cmd(ch, 1'b1, F_W, mk_addr(base + i, 0), fill_word(base + i));
      for (int n = 0; n < RAND_CMDS; n++) begin
         d        = $random(seed);
         is_store = d[0];
         w        = base + int'($unsigned($random(seed)) % RAND_WORDS);
         pos      = int'($unsigned($random(seed)) % 4);
         fn       = pick_funct3(is_store, $unsigned($random(seed)));
         d        = $random(seed);
         run_cmd(ch, is_store, fn, mk_addr(w, pos), d);
      end
   endtask

   initial begin : main
      word_t d;
      seed       = 8;
      cycles     = 0;
      n_checks   = 0;
      n_mismatch = 0;
      n_other    = 0;
      arst_n     = 1'b0;
      for (int c = 0; c < N_CH; c++) begin
         start[c] = 1'b0;
         we[c]    = 1'b0;
         f3[c]    = '0;
         addr[c]  = '0;
         wbit[c]  = 1'b0;
      end
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      repeat (4) begin
         @(negedge clk);
         check_idle();
      end

      d = $random(seed);
      run_cmd(0, 1'b1, F_W, mk_addr(0, 0), d);
      run_cmd(0, 1'b0, F_W, mk_addr(0, 0), '0);

      // sign bits differ per byte and per half.
      run_cmd(0, 1'b1, F_W, mk_addr(1, 0), fill_word(1));
      run_cmd(0, 1'b1, F_W, mk_addr(2, 0), fill_word(2));
      run_cmd(0, 1'b1, F_W, mk_addr(3, 0), 32'h80FF_7F01);
      run_cmd(0, 1'b1, F_W, mk_addr(4, 0), fill_word(4));

      for (int pos = 0; pos < 4; pos++) begin
         run_cmd(0, 1'b1, F_B, mk_addr(1, pos), $random(seed));
         run_cmd(0, 1'b0, F_W, mk_addr(1, 0), '0);
      end
      for (int pos = 0; pos < 4; pos += 2) begin
         run_cmd(0, 1'b1, F_H, mk_addr(2, pos), $random(seed));
         run_cmd(0, 1'b0, F_W, mk_addr(2, 0), '0);
      end

      for (int pos = 0; pos < 4; pos++) begin
         run_cmd(0, 1'b0, F_B, mk_addr(3, pos), '0);
         run_cmd(0, 1'b0, F_BU, mk_addr(3, pos), '0);
      end
      for (int pos = 0; pos < 4; pos += 2) begin
         run_cmd(0, 1'b0, F_H, mk_addr(3, pos), '0);
         run_cmd(0, 1'b0, F_HU, mk_addr(3, pos), '0);
      end

      run_cmd(0, 1'b1, F_H, mk_addr(4, 1), $random(seed));
      run_cmd(0, 1'b1, F_H, mk_addr(4, 3), $random(seed));
      for (int pos = 1; pos < 4; pos++)
         run_cmd(0, 1'b1, F_W, mk_addr(4, pos), $random(seed));
      run_cmd(0, 1'b0, F_H, mk_addr(4, 1), '0);
      run_cmd(0, 1'b0, F_HU, mk_addr(4, 3), '0);
      run_cmd(0, 1'b0, F_W, mk_addr(4, 2), '0);
      run_cmd(0, 1'b0, F_W, mk_addr(4, 0), '0);

      // disjoint word regions per channel.
      fork
         random_cmds(0, 64);
         random_cmds(1, 128);
      join

      repeat (4) @(posedge clk);
      $display("Summary: %0d checks, %0d mismatches, %0d other errors",
               n_checks, n_mismatch, n_other);
      if (n_mismatch == 0 && n_other == 0 && q_got.size() == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

//--- list.f
hw/lsu_pkg.sv
hw/serial_mem_if.sv
hw/lsu_sequencer.sv
hw/mem_arbiter.sv
hw/word_ram.sv
hw/lsu_top.sv
tests/tb_lsu_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator; pass is decided from the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_top \
   -f list.f -o sim_lsu \
   && ./obj_dir/sim_lsu > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^TEST PASS$" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
